// ==== sim.f ====
+incdir+logic
logic/mfp_pkg.sv
logic/mfp_uart_receiver.sv
logic/mfp_uart_loader.sv
logic/mfp_ahb_decoder.sv
logic/mfp_ahb_ram_bank.sv
logic/mfp_ahb_response_mux.sv
logic/mfp_ahb_lite_matrix.sv
logic/mfp_ahb_lite_matrix_with_loader.sv
tb/tb_mfp.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mfp
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A failing run exits with a non-zero status
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_mfp.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module tb_mfp;

    import mfp_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int CYCLE_LIMIT = 200000;    // Whole run needs well under 20000 cycles
    localparam int N_RANDOM    = 200;
    localparam int N_RECORDS   = 10;
    localparam int N_BLOCKED   = 20;

    logic        hclk;
    logic        arst_n;
    mfp_addr_t   haddr;
    mfp_htrans_t htrans;
    logic        hwrite;
    mfp_word_t   hwdata;
    logic        uart_rx;
    mfp_word_t   hrdata;
    logic        hready;
    logic        hresp;
    logic        mfp_reset;

    mfp_word_t   model [mfp_addr_t];        // Keyed by word-aligned byte address
    mfp_addr_t   loaded_addr [$];
    mfp_addr_t   blocked_addr [$];
    int unsigned cycles;

    // Transfer now in its data phase
    logic        pend_valid;
    logic        pend_write;
    mfp_word_t   pend_wdata;
    mfp_word_t   pend_exp;

    mfp_ahb_lite_matrix_with_loader mfp_ahb_lite_matrix_with_loader_inst (
        .hclk      ( hclk      ),
        .arst_n    ( arst_n    ),
        .haddr     ( haddr     ),
        .htrans    ( htrans    ),
        .hwrite    ( hwrite    ),
        .hwdata    ( hwdata    ),
        .uart_rx   ( uart_rx   ),
        .hrdata    ( hrdata    ),
        .hready    ( hready    ),
        .hresp     ( hresp     ),
        .mfp_reset ( mfp_reset )
    );

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD / 2) hclk = ~hclk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge hclk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("TEST FAILED");
                $fatal(1, "Run did not finish within %0d cycles", CYCLE_LIMIT);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Wrong value on %s", name);
        end
    endtask

    // Initial contents depend on every address bit
    function automatic mfp_word_t fill_word(input mfp_addr_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a3c_0f96;
    endfunction

    function automatic mfp_addr_t rand_mapped_addr(input logic [1:0] bank);
        return {20'h0, bank, 8'($urandom), 2'b00};
    endfunction

    // New address phase plus data phase of the previous transfer
    task automatic bus_cycle(input logic valid, input logic wr,
                             input mfp_addr_t addr, input mfp_word_t wdata);
        @(posedge hclk);
        #1;
        haddr  = addr;
        htrans = valid ? HTRANS_NONSEQ : HTRANS_IDLE;
        hwrite = wr;
        hwdata = pend_wdata;
        @(negedge hclk);
        check_value("hready", 32'(hready), 32'h1);
        check_value("hresp", 32'(hresp), 32'h0);
        if (pend_valid && !pend_write) begin
            check_value("hrdata", hrdata, pend_exp);
        end
        if (valid && wr) begin
            model[addr] = wdata;
        end
        if (valid && !wr) begin
            pend_exp = model[addr];
        end
        pend_valid = valid;
        pend_write = wr;
        pend_wdata = wdata;
    endtask

    task automatic host_read(input mfp_addr_t addr);
        bus_cycle(1'b1, 1'b0, addr, '0);
    endtask

    task automatic bus_idle();
        bus_cycle(1'b0, 1'b0, '0, '0);
    endtask

    task automatic preload_memory();
        mfp_addr_t addr;
        for (int i = 0; i < `MFP_N_BANKS * `MFP_BANK_WORDS; i++) begin
            addr = {20'h0, 2'(i % `MFP_N_BANKS), 8'(i / `MFP_N_BANKS), 2'b00};
            bus_cycle(1'b1, 1'b1, addr, fill_word(addr));
        end
        bus_idle();
    endtask

    task automatic random_traffic(input int n);
        logic [1:0] bank;
        mfp_addr_t  addr;
        bank = 2'($urandom);
        for (int i = 0; i < n; i++) begin
            bank = bank + 2'(1 + $urandom_range(2, 0));  // Never the same bank twice
            addr = rand_mapped_addr(bank);
            if ($urandom_range(1, 0) == 1) begin
                bus_cycle(1'b1, 1'b1, addr, $urandom);
            end else begin
                host_read(addr);
            end
        end
        bus_idle();
    endtask

    task automatic unmapped_access();
        mfp_addr_t addr;
        addr = $urandom | (32'h1 << (12 + $urandom_range(19, 0)));
        addr[1:0] = 2'b00;
        bus_idle();
        @(posedge hclk);
        #1;
        haddr  = addr;
        htrans = HTRANS_NONSEQ;
        hwrite = 1'b1;
        @(posedge hclk);
        #1;
        htrans = HTRANS_IDLE;
        hwdata = $urandom;
        @(negedge hclk);
        check_value("hready", 32'(hready), 32'h0);      // First error cycle
        check_value("hresp", 32'(hresp), 32'h1);
        @(negedge hclk);
        check_value("hready", 32'(hready), 32'h1);
        check_value("hresp", 32'(hresp), 32'h1);
        pend_valid = 1'b0;
        host_read(addr & 32'h0000_0ffc);                // Aliased bank word is untouched
        bus_idle();
    endtask

    // One 8N1 frame sent from 1 ns after a rising edge
    task automatic uart_send(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (`MFP_UART_CLKS_PER_BIT) @(posedge hclk);
            #1;
        end
        repeat (`MFP_UART_CLKS_PER_BIT) @(posedge hclk);
        #1;
    endtask

    task automatic uart_load(input int n_records);
        mfp_addr_t   rec_addr [$];
        mfp_word_t   rec_data [$];
        logic [63:0] rec;
        for (int r = 0; r < n_records; r++) begin
            rec_addr.push_back({20'h0, 10'($urandom), 2'b00});
            rec_data.push_back($urandom);
        end
        rec_addr.push_back(`MFP_LOADER_END_ADDR);
        rec_data.push_back($urandom);
        check_value("mfp_reset", 32'(mfp_reset), 32'h0);
        @(posedge hclk);
        #1;
        for (int r = 0; r <= n_records; r++) begin
            rec = {rec_data[r], rec_addr[r]};
            for (int b = 0; b < 8; b++) begin
                uart_send(rec[8*b +: 8]);
                check_value("mfp_reset", 32'(mfp_reset),
                            (r == n_records && b == 7) ? 32'h0 : 32'h1);
            end
            if (r < n_records) begin
                model[rec_addr[r]] = rec_data[r];
                loaded_addr.push_back(rec_addr[r]);
            end
        end
    endtask

    // Host writes the loader masks out stay out of the model
    task automatic blocked_host_writes(input int n);
        mfp_addr_t addr;
        wait (mfp_reset === 1'b1);
        for (int i = 0; i < n; i++) begin
            @(posedge hclk);
            #1;
            check_value("mfp_reset", 32'(mfp_reset), 32'h1);
            addr   = rand_mapped_addr(2'($urandom));
            haddr  = addr;
            htrans = HTRANS_NONSEQ;
            hwrite = 1'b1;
            hwdata = $urandom;
            blocked_addr.push_back(addr);
        end
        @(posedge hclk);
        #1;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
    endtask

    task automatic read_back(input mfp_addr_t addrs [$]);
        foreach (addrs[i]) begin
            host_read(addrs[i]);
        end
        bus_idle();
    endtask

    initial begin
        void'($urandom(38));
        arst_n     = 1'b0;
        haddr      = '0;
        htrans     = HTRANS_IDLE;
        hwrite     = 1'b0;
        hwdata     = '0;
        uart_rx    = 1'b1;
        pend_valid = 1'b0;
        pend_write = 1'b0;
        pend_wdata = '0;
        pend_exp   = '0;
        repeat (8) @(posedge hclk);
        #1;
        arst_n = 1'b1;
        @(negedge hclk);
        check_value("hready", 32'(hready), 32'h1);
        check_value("hresp", 32'(hresp), 32'h0);
        check_value("mfp_reset", 32'(mfp_reset), 32'h0);

        preload_memory();
        random_traffic(N_RANDOM);
        repeat (4) unmapped_access();

        fork
            uart_load(N_RECORDS);
            blocked_host_writes(N_BLOCKED);
        join
        read_back(loaded_addr);
        read_back(blocked_addr);
        random_traffic(N_RANDOM / 4);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== logic/mfp_ahb_lite_matrix_with_loader.sv ====
`timescale 1ns/1ps

module mfp_ahb_lite_matrix_with_loader (
    input  logic                 hclk,
    input  logic                 arst_n,
    input  mfp_pkg::mfp_addr_t   haddr,
    input  mfp_pkg::mfp_htrans_t htrans,
    input  logic                 hwrite,
    input  mfp_pkg::mfp_word_t   hwdata,
    input  logic                 uart_rx,
    output mfp_pkg::mfp_word_t   hrdata,
    output logic                 hready,
    output logic                 hresp,
    output logic                 mfp_reset
);

    import mfp_pkg::*;

    mfp_addr_t   loader_haddr;
    mfp_htrans_t loader_htrans;
    logic        loader_hwrite;
    mfp_word_t   loader_hwdata;
    logic        loader_busy;

    assign mfp_reset = loader_busy;     // Hold the CPU while loading

    mfp_uart_loader loader (
        .hclk          ( hclk          ),
        .arst_n        ( arst_n        ),
        .uart_rx       ( uart_rx       ),
        .hready        ( hready        ),
        .loader_haddr  ( loader_haddr  ),
        .loader_htrans ( loader_htrans ),
        .loader_hwrite ( loader_hwrite ),
        .loader_hwdata ( loader_hwdata ),
        .loader_busy   ( loader_busy   )
    );

    mfp_ahb_lite_matrix matrix (
        .hclk   ( hclk                                    ),
        .arst_n ( arst_n                                  ),
        .haddr  ( loader_busy ? loader_haddr  : haddr     ),
        .htrans ( loader_busy ? loader_htrans : htrans    ),
        .hwrite ( loader_busy ? loader_hwrite : hwrite    ),
        .hwdata ( loader_busy ? loader_hwdata : hwdata    ),
        .hrdata ( hrdata                                  ),
        .hready ( hready                                  ),
        .hresp  ( hresp                                   )
    );

endmodule

// ==== logic/mfp_ahb_lite_matrix.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module mfp_ahb_lite_matrix (
    input  logic                 hclk,
    input  logic                 arst_n,
    input  mfp_pkg::mfp_addr_t   haddr,
    input  mfp_pkg::mfp_htrans_t htrans,
    input  logic                 hwrite,
    input  mfp_pkg::mfp_word_t   hwdata,
    output mfp_pkg::mfp_word_t   hrdata,
    output logic                 hready,
    output logic                 hresp
);

    import mfp_pkg::*;

    logic [`MFP_N_BANKS-1:0]               hsel;
    logic [$clog2(`MFP_N_BANKS)-1:0]       data_sel;
    logic                                  data_default;
    logic                                  default_hready;
    logic                                  default_hresp;
    mfp_word_t [`MFP_N_BANKS-1:0]          bank_hrdata;

    mfp_ahb_decoder decoder (
        .hclk           ( hclk           ),
        .arst_n         ( arst_n         ),
        .haddr          ( haddr          ),
        .htrans         ( htrans         ),
        .hready         ( hready         ),
        .hsel           ( hsel           ),
        .data_sel       ( data_sel       ),
        .data_default   ( data_default   ),
        .default_hready ( default_hready ),
        .default_hresp  ( default_hresp  )
    );

    for (genvar i = 0; i < `MFP_N_BANKS; i++) begin : g_bank
        mfp_ahb_ram_bank bank (
            .hclk        ( hclk           ),
            .arst_n      ( arst_n         ),
            .hsel        ( hsel[i]        ),
            .haddr       ( haddr          ),
            .htrans      ( htrans         ),
            .hwrite      ( hwrite         ),
            .hwdata      ( hwdata         ),
            .hready      ( hready         ),
            .bank_hrdata ( bank_hrdata[i] )
        );
    end

    mfp_ahb_response_mux response_mux (
        .data_sel       ( data_sel       ),
        .data_default   ( data_default   ),
        .bank_hrdata    ( bank_hrdata    ),
        .default_hready ( default_hready ),
        .default_hresp  ( default_hresp  ),
        .hrdata         ( hrdata         ),
        .hready         ( hready         ),
        .hresp          ( hresp          )
    );

endmodule

// ==== logic/mfp_ahb_response_mux.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module mfp_ahb_response_mux (
    input  logic [$clog2(`MFP_N_BANKS)-1:0]         data_sel,
    input  logic                                    data_default,
    input  mfp_pkg::mfp_word_t [`MFP_N_BANKS-1:0]   bank_hrdata,
    input  logic                                    default_hready,
    input  logic                                    default_hresp,
    output mfp_pkg::mfp_word_t                      hrdata,
    output logic                                    hready,
    output logic                                    hresp
);

    import mfp_pkg::*;

    always_comb begin
        if (data_default) begin
            hrdata = '0;
            hready = default_hready;    // Error sequence owns the bus
            hresp  = default_hresp;
        end else begin
            hrdata = bank_hrdata[data_sel];
            hready = 1'b1;              // Banks never stall
            hresp  = 1'b0;
        end

        // Default slave raises an error only in its own data phase
        a_hresp_from_default: assert (data_default || !default_hresp);
    end

endmodule

// ==== logic/mfp_ahb_ram_bank.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module mfp_ahb_ram_bank (
    input  logic                 hclk,
    input  logic                 arst_n,
    input  logic                 hsel,
    input  mfp_pkg::mfp_addr_t   haddr,
    input  mfp_pkg::mfp_htrans_t htrans,
    input  logic                 hwrite,
    input  mfp_pkg::mfp_word_t   hwdata,
    input  logic                 hready,
    output mfp_pkg::mfp_word_t   bank_hrdata
);

    import mfp_pkg::*;

    localparam int WORD_W = $clog2(`MFP_BANK_WORDS);

    mfp_word_t         mem [`MFP_BANK_WORDS];
    logic [WORD_W-1:0] word_q;         // Data-phase word index
    logic              wr_pending;
    logic              access;

    assign access = hsel && hready && (htrans == HTRANS_NONSEQ);

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_pending <= 1'b0;
        end else if (hready) begin
            wr_pending <= access && hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (access) begin
            word_q <= haddr[2 +: WORD_W];
        end
    end

    // Write lands at the end of the data phase
    always_ff @(posedge hclk) begin
        if (wr_pending) begin
            mem[word_q] <= hwdata;
        end
    end

    // Zero wait state read
    assign bank_hrdata = mem[word_q];

endmodule

// ==== logic/mfp_ahb_decoder.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module mfp_ahb_decoder (
    input  logic                               hclk,
    input  logic                               arst_n,
    input  mfp_pkg::mfp_addr_t                 haddr,
    input  mfp_pkg::mfp_htrans_t               htrans,
    input  logic                               hready,
    output logic [`MFP_N_BANKS-1:0]            hsel,
    output logic [$clog2(`MFP_N_BANKS)-1:0]    data_sel,
    output logic                               data_default,
    output logic                               default_hready,
    output logic                               default_hresp
);

    import mfp_pkg::*;

    localparam int BANK_W = $clog2(`MFP_N_BANKS);

    logic              mapped;
    logic [BANK_W-1:0] bank;
    logic              err_second;     // Second cycle of the error response

    assign mapped = (haddr[31:12] == '0);
    assign bank   = haddr[10 +: BANK_W];

    always_comb begin
        hsel = '0;
        if (mapped) hsel[bank] = 1'b1;
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            data_sel     <= '0;
            data_default <= 1'b0;
            err_second   <= 1'b0;
        end else if (hready) begin
            data_sel     <= bank;
            data_default <= (htrans == HTRANS_NONSEQ) && !mapped;
            err_second   <= 1'b0;
        end else if (data_default) begin
            err_second <= 1'b1;
        end
    end

    // Wait with error first, then complete with error
    assign default_hready = !(data_default && !err_second);
    assign default_hresp  = data_default;

    a_hsel_onehot: assert property (
        @(posedge hclk) disable iff (!arst_n) $onehot0(hsel)
    );

endmodule

// ==== logic/mfp_uart_loader.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module mfp_uart_loader (
    input  logic                hclk,
    input  logic                arst_n,
    input  logic                uart_rx,
    input  logic                hready,
    output mfp_pkg::mfp_addr_t  loader_haddr,
    output mfp_pkg::mfp_htrans_t loader_htrans,
    output logic                loader_hwrite,
    output mfp_pkg::mfp_word_t  loader_hwdata,
    output logic                loader_busy
);

    import mfp_pkg::*;

    logic              rx_valid;
    logic [7:0]        rx_byte;
    mfp_loader_state_t state;
    logic [2:0]        byte_cnt;
    mfp_addr_t         rec_addr;
    mfp_word_t         rec_data;
    mfp_addr_t         next_addr;
    logic              take_byte;

    mfp_uart_receiver receiver (
        .hclk     ( hclk     ),
        .arst_n   ( arst_n   ),
        .uart_rx  ( uart_rx  ),
        .rx_valid ( rx_valid ),
        .rx_byte  ( rx_byte  )
    );

    assign take_byte = rx_valid && (state == LDR_IDLE || state == LDR_COLLECT);

    // Address as it stands once the current byte is shifted in
    assign next_addr = {rec_data[7:0], rec_addr[31:8]};

    // Record bytes flow through data into address, so after eight bytes
    // the first four sit in rec_addr
    always_ff @(posedge hclk) begin
        if (take_byte) begin
            rec_addr <= next_addr;
            rec_data <= {rx_byte, rec_data[31:8]};
        end
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= LDR_IDLE;
            byte_cnt    <= '0;
            loader_busy <= 1'b0;
        end else begin
            if (take_byte) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            case (state)
                LDR_IDLE: begin
                    if (rx_valid) begin
                        state       <= LDR_COLLECT;
                        loader_busy <= 1'b1;     // Take the bus
                    end
                end
                LDR_COLLECT: begin
                    if (rx_valid && byte_cnt == 3'd7) begin
                        if (next_addr == `MFP_LOADER_END_ADDR) begin
                            state       <= LDR_IDLE;
                            loader_busy <= 1'b0;
                        end else begin
                            state <= LDR_ADDR_PHASE;
                        end
                    end
                end
                LDR_ADDR_PHASE: begin
                    if (hready) state <= LDR_DATA_PHASE;
                end
                LDR_DATA_PHASE: begin
                    if (hready) state <= LDR_COLLECT;
                end
                default: state <= LDR_IDLE;
            endcase
        end
    end

    assign loader_haddr  = rec_addr;
    assign loader_hwdata = rec_data;
    assign loader_htrans = (state == LDR_ADDR_PHASE) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign loader_hwrite = (state == LDR_ADDR_PHASE);

    // Loader only drives transfers while it owns the bus
    a_no_transfer_when_idle: assert property (
        @(posedge hclk) disable iff (!arst_n)
        loader_htrans == HTRANS_NONSEQ |-> loader_busy
    );

endmodule

// ==== logic/mfp_uart_receiver.sv ====
`timescale 1ns/1ps

`include "mfp_defs.svh"

module mfp_uart_receiver (
    input  logic       hclk,
    input  logic       arst_n,
    input  logic       uart_rx,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int CLKS_PER_BIT = `MFP_UART_CLKS_PER_BIT;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             active;
    logic [3:0]       bit_cnt;      // 0 start, 1..8 data, 9 stop
    logic [CNT_W-1:0] clk_cnt;
    logic [7:0]       shift_reg;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            bit_cnt  <= '0;
            clk_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_sync) begin      // Start bit edge
                    active  <= 1'b1;
                    bit_cnt <= '0;
                    clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0 && rx_sync) begin
                    active <= 1'b0;                 // Glitch, not a start bit
                end else if (bit_cnt == 4'd9) begin
                    active   <= 1'b0;
                    rx_valid <= rx_sync;            // Bad stop bit drops the frame
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge hclk) begin
        if (active && clk_cnt == '0 && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign rx_byte = shift_reg;

endmodule

// ==== logic/mfp_pkg.sv ====
package mfp_pkg;

    typedef logic [31:0] mfp_word_t;    // Data word
    typedef logic [31:0] mfp_addr_t;    // Byte address

    // AHB-Lite transfer type
    typedef logic [1:0] mfp_htrans_t;

    localparam mfp_htrans_t HTRANS_IDLE   = 2'b00;
    localparam mfp_htrans_t HTRANS_NONSEQ = 2'b10;

    // Boot loader FSM
    typedef enum logic [1:0] {
        LDR_IDLE       = 2'd0,
        LDR_COLLECT    = 2'd1,
        LDR_ADDR_PHASE = 2'd2,
        LDR_DATA_PHASE = 2'd3
    } mfp_loader_state_t;

endpackage

// ==== logic/mfp_defs.svh ====
`ifndef MFP_DEFS_SVH
`define MFP_DEFS_SVH

// Number of identical RAM banks behind the decoder
`define MFP_N_BANKS 4

// Words per bank
`define MFP_BANK_WORDS 256

// Clock cycles per serial bit, short for simulation
`define MFP_UART_CLKS_PER_BIT 8

// Record address that closes a load
`define MFP_LOADER_END_ADDR 32'hffff_ffff

`endif
